// ==== event_executor.sv ====
module event_executor #(
    parameter int  VOICES = 8,
    localparam int VW     = (VOICES > 1) ? $clog2(VOICES) : 1,
    localparam int KW     = $clog2(VOICES + 1)
) (
    input  logic                       CLOCK_25,
    input  logic                       iRST_N,
    input  logic                       rd_ack,
    input  logic [midi_pkg::EVT_W-1:0] rd_dat,
    input  logic [VOICES-1:0]          voice_free,
    output logic                       rd_cyc,
    output logic                       rd_stb,
    output logic                       rd_we,
    output logic                       octrl_cmd,
    output logic [7:0]                 octrl,
    output logic [7:0]                 octrl_data,
    output logic                       prg_ch_cmd,
    output logic [7:0]                 prg_ch_data,
    output logic                       pitch_cmd,
    output logic [VOICES-1:0]          keys_on,
    output logic                       note_on,
    output logic                       note_off,
    output logic [VW-1:0]              cur_key_adr,
    output logic [7:0]                 cur_key_val,
    output logic [7:0]                 cur_vel_on,
    output logic [7:0]                 cur_vel_off,
    output logic [KW-1:0]              active_keys,
    output logic                       off_note_error
);

    midi_pkg::evt_kind_t         evt_kind;
    logic [midi_pkg::DATA_W-1:0] evt_d1;
    logic [midi_pkg::DATA_W-1:0] evt_d2;
    logic                        cmd_valid;   // one-cycle command to the allocator
    midi_pkg::evt_kind_t         cmd_kind;
    logic [7:0]                  cmd_key;
    logic [7:0]                  cmd_vel;

    always_comb begin
        midi_pkg::unpack_event(rd_dat, evt_kind, evt_d1, evt_d2);
    end

    // read master with idle cycles between reads
    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            rd_cyc <= 1'b0;
        end else if (rd_ack) begin
            rd_cyc <= 1'b0;
        end else if (!rd_cyc) begin
            rd_cyc <= 1'b1;
        end
    end

    assign rd_stb = rd_cyc;
    assign rd_we  = 1'b0;   // reads only

    // strobes in the cycle after rd_ack
    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            octrl_cmd  <= 1'b0;
            pitch_cmd  <= 1'b0;
            prg_ch_cmd <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            octrl_cmd  <= rd_ack && (evt_kind == midi_pkg::ev_ctrl);
            pitch_cmd  <= rd_ack && (evt_kind == midi_pkg::ev_pitch);
            prg_ch_cmd <= rd_ack && (evt_kind == midi_pkg::ev_prg);
            cmd_valid  <= rd_ack && (evt_kind inside {midi_pkg::ev_note_on,
                                     midi_pkg::ev_note_off, midi_pkg::ev_all_off});
        end
    end

    always_ff @(posedge CLOCK_25) begin
        if (rd_ack) begin
            case (evt_kind)
                midi_pkg::ev_ctrl, midi_pkg::ev_pitch: begin
                    octrl      <= evt_d1;   // controller number or pitch lsb
                    octrl_data <= evt_d2;   // value or pitch msb
                end
                midi_pkg::ev_prg: prg_ch_data <= evt_d1;
                default: ;
            endcase
            cmd_kind <= evt_kind;
            cmd_key  <= evt_d1;
            cmd_vel  <= evt_d2;
        end
    end

    voice_allocator #(.VOICES(VOICES)) alloc_i (.*);

endmodule

// ==== event_fifo.sv ====
module event_fifo #(
    parameter int  FIFO_DEPTH = 8,
    parameter int  WIDTH      = 19,
    localparam int AW         = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
    localparam int CW         = $clog2(FIFO_DEPTH + 1)
) (
    input  logic             CLOCK_25,
    input  logic             iRST_N,
    input  logic             wr_cyc,
    input  logic             wr_stb,
    input  logic             wr_we,
    input  logic [WIDTH-1:0] wr_dat,
    input  logic             rd_cyc,
    input  logic             rd_stb,
    input  logic             rd_we,
    output logic             wr_ack,
    output logic             rd_ack,
    output logic [WIDTH-1:0] rd_dat
);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;      // occupancy
    logic             full;
    logic             empty;
    logic             wr_take;
    logic             rd_take;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;  // wraps for any depth
    endfunction

    assign full    = (count == CW'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign wr_take = wr_cyc && wr_stb && wr_we && !full && !wr_ack;  // one ack per strobe
    assign rd_take = rd_cyc && rd_stb && !rd_we && !empty && !rd_ack;

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ack <= wr_take;
            rd_ack <= rd_take;
            if (wr_take) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_take) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_take, rd_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // level unchanged on both or neither
            endcase
        end
    end

    // storage and head register
    always_ff @(posedge CLOCK_25) begin
        if (wr_take) mem[wr_ptr] <= wr_dat;
        if (rd_take) rd_dat <= mem[rd_ptr];   // valid with rd_ack
    end

endmodule

// ==== midi_decoder.f ====
midi_pkg.sv
midi_parser.sv
event_fifo.sv
voice_allocator.sv
event_executor.sv
midi_decoder.sv
tb_midi_decoder.sv

// ==== midi_decoder.sv ====
module midi_decoder #(
    parameter int  VOICES     = 8,
    parameter int  FIFO_DEPTH = 8,
    localparam int VW         = (VOICES > 1) ? $clog2(VOICES) : 1,
    localparam int KW         = $clog2(VOICES + 1)
) (
    input  logic              CLOCK_25,
    input  logic              iRST_N,
    // from uart
    input  logic              byteready,
    input  logic [7:0]        cur_status,
    input  logic [7:0]        midibyte_nr,
    input  logic [7:0]        midibyte,
    input  logic [3:0]        midi_ch,
    input  logic [VOICES-1:0] voice_free,    // from synth engine
    // voice outputs
    output logic [VOICES-1:0] keys_on,
    output logic              note_on,
    output logic              note_off,
    output logic [VW-1:0]     cur_key_adr,
    output logic [7:0]        cur_key_val,
    output logic [7:0]        cur_vel_on,
    output logic [7:0]        cur_vel_off,
    // controllers
    output logic              octrl_cmd,
    output logic [7:0]        octrl,
    output logic [7:0]        octrl_data,
    output logic              prg_ch_cmd,
    output logic [7:0]        prg_ch_data,
    output logic              pitch_cmd,
    // status
    output logic [KW-1:0]     active_keys,
    output logic              off_note_error,
    output logic              msg_dropped
);

    // parser to buffer
    logic                       wr_cyc;
    logic                       wr_stb;
    logic                       wr_we;
    logic                       wr_ack;
    logic [midi_pkg::EVT_W-1:0] wr_dat;
    // buffer to executor
    logic                       rd_cyc;
    logic                       rd_stb;
    logic                       rd_we;
    logic                       rd_ack;
    logic [midi_pkg::EVT_W-1:0] rd_dat;

    midi_parser parser_i (.*);

    event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .WIDTH      (midi_pkg::EVT_W)
    ) fifo_i (.*);

    event_executor #(.VOICES(VOICES)) exec_i (.*);

endmodule

// ==== midi_decoder_golden.txt ====
# T <test>, B <status> <byte nr> <data> in hex, listening channel 3
# E <kind> <fields hex>: 1 note on / 2 note off = adr key_val vel keys_on active_keys
# 3 ctrl = octrl octrl_data, 4 program = prg_ch_data, 5 pitch = lsb msb
# 0 state after the test = off_note_error keys_on active_keys msg_dropped
T 1
B 93 01 3C
B 93 02 40
B 93 03 40
B 93 04 50
B 93 05 43
B 93 06 60
E 1 0 3C 40 01 1
E 1 1 40 50 03 2
E 1 2 43 60 07 3
T 2
B 93 01 45
B 93 02 41
B 93 03 47
B 93 04 42
B 95 01 3C
B 95 02 7F
B 93 05 48
B 93 06 43
B 93 07 4A
B 93 08 44
B 93 09 4C
B 93 0A 45
B 93 0B 4F
B 93 0C 46
E 1 3 45 41 0F 4
E 1 4 47 42 1F 5
E 1 5 48 43 3F 6
E 1 6 4A 44 7F 7
E 1 7 4C 45 FF 8
E 1 0 4F 46 FF 8
T 3
B 83 01 40
B 83 02 22
B 84 01 4F
B 84 02 00
B 83 03 3C
B 83 04 10
E 2 1 FF 22 FD 7
E 0 1 FD 7 0
T 4
B B3 01 7B
B B3 02 00
E 0 0 00 0 0
T 5
B B3 01 07
B B5 01 11
B B3 02 64
B C3 01 05
B C5 01 09
B E3 01 00
B E3 02 40
E 3 07 64
E 4 05
E 5 00 40
T 6
B 93 01 3C
B 93 02 64
B B3 01 0A
B B3 02 20
B 95 01 60
B 95 02 40
B C3 01 09
B 83 01 3C
B 83 02 30
B E3 01 7F
B E3 02 7F
E 1 0 3C 64 01 1
E 3 0A 20
E 4 09
E 2 0 FF 30 00 0
E 5 7F 7F
E 0 0 00 0 0

// ==== midi_parser.sv ====
module midi_parser (
    input  logic                       CLOCK_25,
    input  logic                       iRST_N,
    input  logic                       byteready,
    input  logic [7:0]                 cur_status,
    input  logic [7:0]                 midibyte_nr,
    input  logic [7:0]                 midibyte,
    input  logic [3:0]                 midi_ch,
    input  logic                       wr_ack,
    output logic                       wr_cyc,
    output logic                       wr_stb,
    output logic                       wr_we,
    output logic [midi_pkg::EVT_W-1:0] wr_dat,
    output logic                       msg_dropped
);

    logic                        byte_vld;   // registered byte on our channel
    logic [3:0]                  st_nib;
    logic [7:0]                  byte_nr;
    logic [midi_pkg::DATA_W-1:0] data_r;
    logic [midi_pkg::DATA_W-1:0] first_r;    // first data byte of the message
    logic                        is_first;
    logic                        is_second;
    logic                        msg_done;
    midi_pkg::evt_kind_t         msg_kind;
    logic [midi_pkg::DATA_W-1:0] msg_d1;
    logic [midi_pkg::DATA_W-1:0] msg_d2;

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            byte_vld <= 1'b0;
        end else begin
            byte_vld <= byteready && (cur_status[3:0] == midi_ch); // channel filter
        end
    end

    // byte payload qualified by byte_vld
    always_ff @(posedge CLOCK_25) begin
        st_nib  <= cur_status[7:4];
        byte_nr <= midibyte_nr;
        data_r  <= midibyte;
    end

    assign is_first  = byte_nr[0];                          // odd numbers
    assign is_second = !byte_nr[0] && (byte_nr != 8'd0);    // even and not the status byte

    always_ff @(posedge CLOCK_25) begin
        if (byte_vld && is_first) begin
            first_r <= data_r;
        end
    end

    // message assembly
    always_comb begin
        msg_done = 1'b0;
        msg_kind = midi_pkg::ev_ctrl;
        msg_d1   = first_r;
        msg_d2   = data_r;
        if (byte_vld) begin
            case (st_nib)
                midi_pkg::st_note_on: begin
                    msg_done = is_second;
                    msg_kind = midi_pkg::ev_note_on;
                end
                midi_pkg::st_note_off: begin
                    msg_done = is_second;
                    msg_kind = midi_pkg::ev_note_off;
                end
                midi_pkg::st_ctrl: begin
                    msg_done = is_second;
                    msg_kind = (first_r == midi_pkg::cc_all_notes_off) ?
                               midi_pkg::ev_all_off : midi_pkg::ev_ctrl;
                end
                midi_pkg::st_pitch: begin
                    msg_done = is_second;
                    msg_kind = midi_pkg::ev_pitch;
                end
                midi_pkg::st_prg_change: begin
                    msg_done = is_first;   // single data byte
                    msg_kind = midi_pkg::ev_prg;
                    msg_d1   = data_r;
                    msg_d2   = '0;
                end
                default: ;                 // other status ignored
            endcase
        end
    end

    // wishbone write master
    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            wr_cyc      <= 1'b0;
            msg_dropped <= 1'b0;
        end else begin
            if (wr_ack) begin
                wr_cyc <= 1'b0;              // release bus after ack
            end
            if (msg_done) begin
                if (wr_cyc && !wr_ack) begin
                    msg_dropped <= 1'b1;     // message lost while the buffer stalls
                end else begin
                    wr_cyc <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_25) begin
        if (msg_done && (!wr_cyc || wr_ack)) begin
            wr_dat <= midi_pkg::pack_event(msg_kind, msg_d1, msg_d2);
        end
    end

    assign wr_stb = wr_cyc;
    assign wr_we  = wr_cyc;   // write-only master

endmodule

// ==== midi_pkg.sv ====
package midi_pkg;

    // status high nibbles with the channel in the low nibble
    localparam logic [3:0] st_note_off   = 4'h8;
    localparam logic [3:0] st_note_on    = 4'h9;
    localparam logic [3:0] st_ctrl       = 4'hB;
    localparam logic [3:0] st_prg_change = 4'hC;
    localparam logic [3:0] st_pitch      = 4'hE;

    localparam logic [7:0] cc_all_notes_off = 8'h7B; // controller 123

    // field widths
    localparam int DATA_W = 8;                   // one midi data field
    localparam int KIND_W = 3;
    localparam int EVT_W  = KIND_W + 2 * DATA_W; // 19 bits per event

    typedef enum logic [KIND_W-1:0] {
        ev_note_on,
        ev_note_off,
        ev_all_off,   // controller 0x7b
        ev_ctrl,
        ev_prg,
        ev_pitch
    } evt_kind_t;

    // kind in the top bits, then first data byte, then second
    function automatic logic [EVT_W-1:0] pack_event(
        input evt_kind_t         kind,
        input logic [DATA_W-1:0] d1,   // key, controller, program or pitch lsb
        input logic [DATA_W-1:0] d2    // velocity, value or pitch msb
    );
        return {kind, d1, d2};
    endfunction

    function automatic void unpack_event(
        input  logic [EVT_W-1:0]  evt,
        output evt_kind_t         kind,
        output logic [DATA_W-1:0] d1,
        output logic [DATA_W-1:0] d2
    );
        kind = evt_kind_t'(evt[EVT_W-1 -: KIND_W]);
        d1   = evt[2*DATA_W-1 -: DATA_W];
        d2   = evt[DATA_W-1:0];
    endfunction

endpackage

// ==== tb_midi_decoder.sv ====
module tb_midi_decoder;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int VOICES = 8;

    logic              CLOCK_25;
    logic              iRST_N;
    logic              byteready;
    logic [7:0]        cur_status;
    logic [7:0]        midibyte_nr;
    logic [7:0]        midibyte;
    logic [3:0]        midi_ch;
    logic [VOICES-1:0] voice_free;
    logic [VOICES-1:0] keys_on;
    logic              note_on;
    logic              note_off;
    logic [2:0]        cur_key_adr;
    logic [7:0]        cur_key_val;
    logic [7:0]        cur_vel_on;
    logic [7:0]        cur_vel_off;
    logic              octrl_cmd;
    logic [7:0]        octrl;
    logic [7:0]        octrl_data;
    logic              prg_ch_cmd;
    logic [7:0]        prg_ch_data;
    logic              pitch_cmd;
    logic [3:0]        active_keys;
    logic              off_note_error;
    logic              msg_dropped;

    // golden records as a tag plus up to six fields
    logic [7:0]  rec_tag [$];
    logic [47:0] rec_val [$];
    int          test_start [$];     // record index of each T line
    int          n_bytes = 0;

    // expected strobes with the oldest at the front
    logic [7:0]  exp_kind [$];
    logic [39:0] exp_val  [$];

    integer seed        = 32'he8e9;  // byte gap source
    int     err_cnt     = 0;
    int     cycles      = 0;
    int     cycle_limit = 0;         // set from the byte count

    midi_decoder #(.VOICES(VOICES), .FIFO_DEPTH(8)) dut_i (.*);

    initial begin
        CLOCK_25 = 1'b0;
        forever #2 CLOCK_25 = ~CLOCK_25;   // 4 ns period
    end

    function automatic string strobe_name(input logic [7:0] kind);
        case (kind)
            8'd1:    return "note_on";
            8'd2:    return "note_off";
            8'd3:    return "octrl_cmd";
            8'd4:    return "prg_ch_cmd";
            8'd5:    return "pitch_cmd";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic load_golden();
        integer fd;
        integer rc;
        string  line;
        integer k;
        integer a;
        integer b;
        integer c;
        integer d;
        integer e;
        fd = $fopen("midi_decoder_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open midi_decoder_golden.txt");
            err_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            // short E lines leave zeros
            k = 0;
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            e = 0;
            case (line.getc(0))
                "T": begin
                    rc = $sscanf(line, "T %d", a);
                    test_start.push_back(rec_tag.size());
                    rec_tag.push_back("T");
                    rec_val.push_back(48'(a));
                end
                "B": begin
                    rc = $sscanf(line, "B %h %h %h", a, b, c);
                    rec_tag.push_back("B");
                    rec_val.push_back({24'h0, a[7:0], b[7:0], c[7:0]});
                    n_bytes++;
                end
                "E": begin
                    rc = $sscanf(line, "E %d %h %h %h %h %h", k, a, b, c, d, e);
                    rec_tag.push_back("E");
                    rec_val.push_back({k[7:0], a[7:0], b[7:0], c[7:0], d[7:0], e[7:0]});
                end
                default: ;   // comment or blank
            endcase
        end
        $fclose(fd);
    endtask

    // one byte from the uart followed by a random idle gap
    task automatic send_byte(input logic [7:0] st, input logic [7:0] nr, input logic [7:0] dat);
        int gap;
        gap = 2 + ($unsigned($random(seed)) % 8);   // 2 to 9 cycles
        @(posedge CLOCK_25);
        byteready   <= 1'b1;
        cur_status  <= st;
        midibyte_nr <= nr;
        midibyte    <= dat;
        @(posedge CLOCK_25);
        byteready <= 1'b0;
        repeat (gap - 1) @(posedge CLOCK_25);
    endtask

    // parser, fifo and executor all empty for a few cycles
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 6) begin
            @(posedge CLOCK_25);
            if (!dut_i.parser_i.byte_vld && !dut_i.wr_cyc && (dut_i.fifo_i.count == 0) &&
                !dut_i.rd_ack && !dut_i.exec_i.cmd_valid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic take_event(input logic [7:0] kind);
        logic [7:0]  want;
        logic [39:0] v;
        if (exp_kind.size() == 0) begin
            $display("unexpected %s strobe, no event was expected", strobe_name(kind));
            err_cnt++;
        end else begin
            want = exp_kind.pop_front();
            v    = exp_val.pop_front();
            if (want != kind) begin
                $display("%s strobe came while %s was expected",
                         strobe_name(kind), strobe_name(want));
                err_cnt++;
            end else if (kind == 8'd1 || kind == 8'd2) begin
                check_val("cur_key_adr", cur_key_adr, v[39:32]);
                check_val("cur_key_val", cur_key_val, v[31:24]);
                if (kind == 8'd1) begin
                    check_val("cur_vel_on", cur_vel_on, v[23:16]);
                end else begin
                    check_val("cur_vel_off", cur_vel_off, v[23:16]);
                end
                check_val("keys_on", keys_on, v[15:8]);
                check_val("active_keys", active_keys, v[7:0]);
            end else if (kind == 8'd4) begin
                check_val("prg_ch_data", prg_ch_data, v[39:32]);
            end else begin
                check_val("octrl", octrl, v[39:32]);          // controller or pitch lsb
                check_val("octrl_data", octrl_data, v[31:24]);
            end
        end
    endtask

    // sticky state once the pipeline has drained
    task automatic check_state(input logic [39:0] v);
        check_val("off_note_error", off_note_error, v[39:32]);
        check_val("keys_on", keys_on, v[31:24]);
        check_val("active_keys", active_keys, v[23:16]);
        check_val("msg_dropped", msg_dropped, v[15:8]);
    endtask

    // strobe monitor sampling the values of the previous cycle
    always @(posedge CLOCK_25) begin
        if (iRST_N) begin
            if (note_on)    take_event(8'd1);
            if (note_off)   take_event(8'd2);
            if (octrl_cmd)  take_event(8'd3);
            if (prg_ch_cmd) take_event(8'd4);
            if (pitch_cmd)  take_event(8'd5);
        end
    end

    always @(posedge CLOCK_25) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin : main_seq
        int          rec_lo;
        int          rec_hi;
        int          test_no;
        int          errs_before;
        int          n_pass;
        int          n_fail;
        logic [47:0] v;
        n_pass      = 0;
        n_fail      = 0;
        iRST_N      = 1'b0;
        byteready   = 1'b0;
        cur_status  = 8'h00;
        midibyte_nr = 8'h00;
        midibyte    = 8'h00;
        midi_ch     = 4'h3;            // listening channel
        voice_free  = '1;              // engine never holds a voice
        load_golden();
        cycle_limit = n_bytes * 16 + 1000;
        repeat (16) @(posedge CLOCK_25);
        iRST_N <= 1'b1;
        @(posedge CLOCK_25);
        for (int t = 0; t < test_start.size(); t++) begin
            rec_lo      = test_start[t] + 1;
            rec_hi      = (t + 1 < test_start.size()) ? test_start[t + 1] : rec_tag.size();
            test_no     = rec_val[test_start[t]][15:0];
            errs_before = err_cnt;
            // queue strobes first since they can show up before the test's last byte
            for (int i = rec_lo; i < rec_hi; i++) begin
                v = rec_val[i];
                if (rec_tag[i] == "E" && v[47:40] != 8'd0) begin
                    exp_kind.push_back(v[47:40]);
                    exp_val.push_back(v[39:0]);
                end
            end
            for (int i = rec_lo; i < rec_hi; i++) begin
                v = rec_val[i];
                if (rec_tag[i] == "B") send_byte(v[23:16], v[15:8], v[7:0]);
            end
            wait_idle();
            if (exp_kind.size() != 0) begin
                $display("test %0d: %0d expected events never came out", test_no, exp_kind.size());
                err_cnt++;
                exp_kind.delete();
                exp_val.delete();
            end
            for (int i = rec_lo; i < rec_hi; i++) begin
                v = rec_val[i];
                if (rec_tag[i] == "E" && v[47:40] == 8'd0) check_state(v[39:0]);
            end
            if (err_cnt == errs_before) begin
                $display("test %0d: pass", test_no);
                n_pass++;
            end else begin
                $display("test %0d: FAIL with %0d errors", test_no, err_cnt - errs_before);
                n_fail++;
            end
        end
        $display("%0d run, %0d passed, %0d failed, %0d errors",
                 test_start.size(), n_pass, n_fail, err_cnt);
        if (err_cnt == 0 && test_start.size() > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== voice_allocator.sv ====
module voice_allocator #(
    parameter int  VOICES = 8,
    localparam int VW     = (VOICES > 1) ? $clog2(VOICES) : 1,
    localparam int KW     = $clog2(VOICES + 1)
) (
    input  logic                CLOCK_25,
    input  logic                iRST_N,
    input  logic                cmd_valid,
    input  midi_pkg::evt_kind_t cmd_kind,
    input  logic [7:0]          cmd_key,
    input  logic [7:0]          cmd_vel,
    input  logic [VOICES-1:0]   voice_free,
    output logic [VOICES-1:0]   keys_on,
    output logic                note_on,
    output logic                note_off,
    output logic [VW-1:0]       cur_key_adr,
    output logic [7:0]          cur_key_val,
    output logic [7:0]          cur_vel_on,
    output logic [7:0]          cur_vel_off,
    output logic [KW-1:0]       active_keys,
    output logic                off_note_error
);

    logic [7:0]    key_val [VOICES];  // key held per voice
    logic [VW-1:0] age     [VOICES];  // rank among on voices with 0 newest

    logic          free_found;
    logic [VW-1:0] free_idx;
    logic [VW-1:0] old_idx;     // oldest on voice to steal
    logic [VW-1:0] on_idx;      // voice for the next note-on
    logic          hit_found;
    logic [VW-1:0] hit_idx;     // voice holding cmd_key

    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        hit_found  = 1'b0;
        hit_idx    = '0;
        old_idx    = '0;
        // walk down so the lowest index is the last one kept
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (!keys_on[i] && voice_free[i]) begin
                free_found = 1'b1;
                free_idx   = VW'(i);
            end
            if (keys_on[i] && (key_val[i] == cmd_key)) begin
                hit_found = 1'b1;
                hit_idx   = VW'(i);
            end
        end
        for (int i = 0; i < VOICES; i++) begin
            if (keys_on[i] && (!keys_on[old_idx] || (age[i] > age[old_idx]))) begin
                old_idx = VW'(i);
            end
        end
        on_idx = free_found ? free_idx : old_idx;   // voice 0 if nothing is on
    end

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            keys_on        <= '0;
            note_on        <= 1'b0;
            note_off       <= 1'b0;
            cur_key_adr    <= '0;
            cur_key_val    <= 8'hFF;
            cur_vel_on     <= '0;
            cur_vel_off    <= '0;
            active_keys    <= '0;
            off_note_error <= 1'b0;
            for (int i = 0; i < VOICES; i++) begin
                age[i] <= '0;
            end
        end else begin
            note_on  <= 1'b0;
            note_off <= 1'b0;
            if (cmd_valid) begin
                case (cmd_kind)
                    midi_pkg::ev_note_on: begin
                        // age all on voices or only those younger than the stolen one
                        for (int i = 0; i < VOICES; i++) begin
                            if (keys_on[i] && (!keys_on[on_idx] || (age[i] < age[on_idx]))) begin
                                age[i] <= age[i] + 1'b1;
                            end
                        end
                        age[on_idx]     <= '0;
                        keys_on[on_idx] <= 1'b1;
                        if (!keys_on[on_idx]) begin
                            active_keys <= active_keys + 1'b1;  // steal keeps the count
                        end
                        cur_key_adr <= on_idx;
                        cur_key_val <= cmd_key;
                        cur_vel_on  <= cmd_vel;
                        note_on     <= 1'b1;
                    end
                    midi_pkg::ev_note_off: begin
                        if (hit_found) begin
                            for (int i = 0; i < VOICES; i++) begin
                                if (keys_on[i] && (age[i] > age[hit_idx])) begin
                                    age[i] <= age[i] - 1'b1;  // close the gap
                                end
                            end
                            keys_on[hit_idx] <= 1'b0;
                            active_keys      <= active_keys - 1'b1;
                            cur_key_adr      <= hit_idx;
                            cur_key_val      <= 8'hFF;   // voice released
                            cur_vel_off      <= cmd_vel;
                            note_off         <= 1'b1;
                        end else begin
                            off_note_error <= 1'b1;   // no voice holds this key
                        end
                    end
                    midi_pkg::ev_all_off: begin
                        keys_on        <= '0;
                        active_keys    <= '0;
                        off_note_error <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    // key table
    always_ff @(posedge CLOCK_25) begin
        if (cmd_valid && (cmd_kind == midi_pkg::ev_note_on)) begin
            key_val[on_idx] <= cmd_key;
        end
    end

endmodule
